// File: verilog/positPkg.sv
// posit constants, field widths, stage payload structs and special words
`default_nettype none

package positPkg;

  ////////////////////
  // format constants
  ////////////////////

  localparam int posN   = 16;               // posit word width
  localparam int posEs  = 2;                // exponent field width
  localparam int regW   = $clog2(posN) + 1; // signed regime count, 5 bits
  localparam int scaleW = regW + posEs + 2; // signed k*4+e, room for a difference
  localparam int fracW  = posN - 2;         // hidden one plus widest fraction

  ////////////////////
  // words and payloads
  ////////////////////

  typedef logic [posN-1:0] posWord_t;       // raw posit word

  // operand pair on the input handshake
  typedef struct packed {
    posWord_t a;                            // dividend
    posWord_t b;                            // divisor
  } operands_t;

  // one operand after decode
  typedef struct packed {
    logic                    sign;          // original sign bit
    logic signed [regW-1:0]  k;             // regime value
    logic [posEs-1:0]        exp;           // exponent bits, zero filled
    logic [fracW-1:0]        frac;          // hidden one at msb
    logic                    isZero;
    logic                    isNar;
  } decoded_t;

  // stage 1 payload
  typedef struct packed {
    decoded_t num;
    decoded_t den;
  } decPair_t;

  // stage 2 payload, quotient before rounding
  typedef struct packed {
    logic                     sign;
    logic signed [scaleW-1:0] scale;        // combined 2^scale
    logic [2*fracW-1:0]       mant;         // leading one at msb
    logic                     sticky;       // nonzero division remainder
    logic                     isZero;
    logic                     isNar;
  } quotRaw_t;

  ////////////////////
  // special words
  ////////////////////

  localparam posWord_t posZero = '0;
  localparam posWord_t posNar  = {1'b1, {(posN-1){1'b0}}};   // 0x8000

endpackage : positPkg

`default_nettype wire

// File: verilog/positDecode.sv
// posit word decoder into sign, regime count, exponent, fraction and special flags
`default_nettype none

module positDecode (
  input  positPkg::posWord_t word,
  output positPkg::decoded_t dec
);
  import positPkg::*;

  posWord_t        absWord;                 // magnitude, two's complement of negatives
  logic [posN-2:0] body;                    // bits below the sign
  logic [posN-2:0] rem;                     // bits after the regime terminator
  logic [regW-1:0] runLen;                  // length of leading identical run
  logic            runDone;
  logic            runBit;                  // value of the regime run

  ////////////////////
  // regime run
  ////////////////////

  always_comb
  begin
    absWord = word[posN-1] ? -word : word;
    body    = absWord[posN-2:0];
    runBit  = body[posN-2];

    // count from the top until the first differing bit
    runLen  = '0;
    runDone = 1'b0;
    for (int i = posN - 2; i >= 0; i--)
    begin
      if (!runDone && (body[i] == runBit))
        runLen = runLen + 1'b1;
      else
        runDone = 1'b1;                     // terminator found
    end

    // drop run and terminator, rest moves to the top
    // a full-width run shifts everything out, exp and frac become zero
    rem = body << (runLen + 1'b1);
  end

  ////////////////////
  // fields
  ////////////////////

  always_comb
  begin
    dec.sign   = word[posN-1];

    // ones run of m gives k = m-1, zeros run of m gives k = -m
    if (runBit)
      dec.k = runLen - 1'b1;
    else
      dec.k = -runLen;

    dec.exp    = rem[posN-2 -: posEs];      // missing exp bits already zero
    dec.frac   = {1'b1, rem[posN-2-posEs:0]};   // hidden one always set

    // NaR decodes like zero in the body, only the sign bit differs
    dec.isZero = (word == posZero);
    dec.isNar  = (word == posNar);
  end

endmodule : positDecode

`default_nettype wire

// File: verilog/positDivArith.sv
// posit division arithmetic: fraction divide, normalise, scale, sign and special flags
`default_nettype none

module positDivArith (
  input  positPkg::decoded_t num,
  input  positPkg::decoded_t den,
  output positPkg::quotRaw_t quot
);
  import positPkg::*;

  logic [2*fracW-1:0]       dividend;       // num fraction shifted up by fracW
  logic [2*fracW-1:0]       divisor;
  logic [2*fracW-1:0]       qFull;          // ratio times 2^fracW
  logic [2*fracW-1:0]       rFull;          // remainder for sticky
  logic                     belowOne;       // ratio in (0.5, 1)
  logic signed [scaleW-1:0] kDiff;
  logic signed [scaleW-1:0] eDiff;

  ////////////////////
  // fraction divide
  ////////////////////

  always_comb
  begin
    dividend = {num.frac, {fracW{1'b0}}};
    divisor  = {{fracW{1'b0}}, den.frac};   // hidden one keeps it nonzero

    // both fractions in [1,2) so the ratio sits in (0.5, 2)
    qFull    = dividend / divisor;
    rFull    = dividend % divisor;

    // bit fracW is the integer one of the ratio
    belowOne = ~qFull[fracW];

    if (belowOne)
      quot.mant = qFull << fracW;           // one extra place up, leading one at msb
    else
      quot.mant = qFull << (fracW - 1);     // integer one lands on the msb

    quot.sticky = |rFull;                   // inexact quotient
  end

  ////////////////////
  // scale and sign
  ////////////////////

  always_comb
  begin
    // sign extended into the wider scale
    kDiff = $signed(num.k) - $signed(den.k);
    eDiff = $signed({1'b0, num.exp}) - $signed({1'b0, den.exp});

    // regime weight is 2^(2^posEs), normalise shift takes one away
    quot.scale = (kDiff <<< posEs) + eDiff - $signed({1'b0, belowOne});

    quot.sign  = num.sign ^ den.sign;
  end

  ////////////////////
  // special cases
  ////////////////////

  always_comb
  begin
    // NaR operand or divide by zero
    quot.isNar  = num.isNar | den.isNar | den.isZero;
    quot.isZero = num.isZero & ~quot.isNar;     // NaR wins over zero
  end

endmodule : positDivArith

`default_nettype wire

// File: verilog/positEncode.sv
// posit encoder with regime build, round to nearest even and saturation
`default_nettype none

module positEncode (
  input  positPkg::quotRaw_t raw,
  output positPkg::posWord_t word
);
  import positPkg::*;

  localparam int kMax  = posN - 2;                  // regime of maxpos
  localparam int seedW = 2 + posEs + 2*fracW - 1;   // run start, terminator, exp, frac
  localparam int extW  = 3*posN;                    // longest shift loses no bits

  localparam posWord_t posMax = {1'b0, {(posN-1){1'b1}}};
  localparam posWord_t posMin = {{(posN-1){1'b0}}, 1'b1};

  logic signed [scaleW-1:0] kReg;           // floor(scale / 4)
  logic [posEs-1:0]         expBits;        // scale mod 4
  logic [seedW-1:0]         seed;
  logic signed [extW-1:0]   seedExt;
  logic signed [extW-1:0]   shifted;
  logic [regW-1:0]          shAmt;
  logic [posN-2:0]          bodyBits;       // unrounded word below the sign
  logic                     guardBit;
  logic                     stickyBit;
  logic                     roundUp;
  logic                     satHigh;
  logic                     satLow;
  posWord_t                 magWord;        // rounded magnitude

  ////////////////////
  // scale split
  ////////////////////

  always_comb
  begin
    kReg    = $signed(raw.scale) >>> posEs; // arithmetic, floors negatives
    expBits = raw.scale[posEs-1:0];

    satHigh = (kReg >= kMax);               // at or past maxpos
    satLow  = (kReg < -kMax);               // below minpos
  end

  ////////////////////
  // regime, exp, frac
  ////////////////////

  always_comb
  begin
    // k >= 0 starts with 10, k < 0 with 01
    if (kReg[scaleW-1])
      seed = {2'b01, expBits, raw.mant[2*fracW-2:0]};
    else
      seed = {2'b10, expBits, raw.mant[2*fracW-2:0]};

    // ones run of k+1, or zeros run of -k
    if (kReg[scaleW-1])
      shAmt = regW'(-kReg - 1);
    else
      shAmt = regW'(kReg);

    seedExt = {seed, {(extW-seedW){1'b0}}};

    // sign fill copies the run bit, ones for k >= 0 and zeros otherwise
    shifted = seedExt >>> shAmt;

    bodyBits  = shifted[extW-1 -: posN-1];
    guardBit  = shifted[extW-posN];
    stickyBit = (|shifted[extW-posN-1:0]) | raw.sticky;
  end

  ////////////////////
  // rounding
  ////////////////////

  always_comb
  begin
    // nearest even, ties go to an even lsb
    roundUp = guardBit & (stickyBit | bodyBits[0]);
    magWord = {1'b0, bodyBits} + posWord_t'(roundUp);

    // clamp to the posit range, never to zero or NaR
    if (satHigh)
      magWord = posMax;
    else if (satLow)
      magWord = posMin;
  end

  ////////////////////
  // final word
  ////////////////////

  always_comb
  begin
    if (raw.isNar)
      word = posNar;
    else if (raw.isZero)
      word = posZero;
    else if (raw.sign)
      word = -magWord;                      // negative posits are two's complement
    else
      word = magWord;
  end

endmodule : positEncode

`default_nettype wire

// File: verilog/positDivPipe.sv
// posit divider top: three valid/ready stage registers, decoders, arithmetic, encoder
`default_nettype none

module positDivPipe (
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  output logic                inReady,
  input  positPkg::operands_t inData,
  output logic                outValid,
  input  logic                outReady,
  output positPkg::posWord_t  outData
);
  import positPkg::*;

  decoded_t decNum;                         // stage 1 inputs
  decoded_t decDen;
  quotRaw_t quotNext;                       // stage 2 input
  posWord_t wordNext;                       // stage 3 input

  logic     s1Valid, s2Valid, s3Valid;
  logic     s1Ready, s2Ready, s3Ready;
  decPair_t s1Data;
  quotRaw_t s2Data;
  posWord_t s3Data;

  ////////////////////
  // datapath
  ////////////////////

  positDecode decA (.word(inData.a), .dec(decNum));
  positDecode decB (.word(inData.b), .dec(decDen));

  positDivArith arith (
    .num (s1Data.num),
    .den (s1Data.den),
    .quot(quotNext)
  );

  positEncode enc (.raw(s2Data), .word(wordNext));

  ////////////////////
  // ready chain
  ////////////////////

  // a stage loads when empty or when it drains this cycle
  assign s3Ready = ~s3Valid | outReady;
  assign s2Ready = ~s2Valid | s3Ready;
  assign s1Ready = ~s1Valid | s2Ready;
  assign inReady = s1Ready;

  ////////////////////
  // valid flags
  ////////////////////

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
      s3Valid <= 1'b0;
    end
    else
    begin
      if (s1Ready) s1Valid <= inValid;      // bubble if nothing offered
      if (s2Ready) s2Valid <= s1Valid;
      if (s3Ready) s3Valid <= s2Valid;
    end
  end

  ////////////////////
  // stage payloads
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (s1Ready && inValid)
      s1Data <= '{num: decNum, den: decDen};
    if (s2Ready && s1Valid)
      s2Data <= quotNext;
    if (s3Ready && s2Valid)
      s3Data <= wordNext;                   // held while outReady low
  end

  assign outValid = s3Valid;
  assign outData  = s3Data;

endmodule : positDivPipe

`default_nettype wire

// File: dv/positDiv_asserts.sv
// handshake stability, latency and reset checks bound to the posit divider top
`default_nettype none

module positDivAsserts (
  input logic               clk,
  input logic               arstN,
  input logic               inValid,
  input logic               inReady,
  input logic               outValid,
  input logic               outReady,
  input positPkg::posWord_t outData
);

  int failCount = 0;                        // failures seen so far

  ////////////////////
  // stall stability
  ////////////////////

  outValidHold: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> outValid)
  else
  begin
    $error("outValid dropped before its transfer");
    failCount++;
  end

  outDataHold: assert property (@(posedge clk) disable iff (!arstN)
    outValid && !outReady |=> $stable(outData))
  else
  begin
    $error("outData changed while stalled");
    failCount++;
  end

  ////////////////////
  // latency and reset
  ////////////////////

  // accepted at T0, outReady high at T1 and T2, result valid at T3
  latency3: assert property (@(posedge clk) disable iff (!arstN)
    $past(inValid && inReady, 3) && $past(outReady, 2) && $past(outReady, 1) |-> outValid)
  else
  begin
    $error("quotient missing three cycles after its input");
    failCount++;
  end

  resetIdle: assert property (@(posedge clk)
    !arstN |-> !outValid && inReady)
  else
  begin
    $error("pipeline not empty during reset");
    failCount++;
  end

endmodule : positDivAsserts

`default_nettype wire

// File: dv/positDivTb.sv
// posit divider testbench with clock, reset, stimulus groups, scoreboard and watchdog
`default_nettype none

module positDivTb;
  import positPkg::*;

  localparam int nSpecial   = 8 * 4 + 4;    // four specials per round, four corners
  localparam int nIdent     = 2 * 40;
  localparam int nSign      = 2 * 20;
  localparam int nPow       = 60;
  localparam int nFlow      = 100;
  localparam int nTx        = nSpecial + nIdent + nSign + nPow + nFlow;
  localparam int cycleLimit = 10 * nTx + 100;

  localparam posWord_t posOne    = 16'h4000;   // 1.0
  localparam posWord_t posNegOne = 16'hC000;   // -1.0

  logic      clk;
  logic      arstN;
  logic      inValid;
  logic      inReady;
  operands_t inData;
  logic      outValid;
  logic      outReady;
  posWord_t  outData;

  posWord_t  expQ[$];                       // expected quotients in input order
  posWord_t  expWord;
  int        cycleCount  = 0;
  int        dataErrors  = 0;
  int        orderErrors = 0;
  bit        randomReady = 1'b0;            // outReady random or held high

  positDivPipe u_dut (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .inReady (inReady),
    .inData  (inData),
    .outValid(outValid),
    .outReady(outReady),
    .outData (outData)
  );

  bind positDivPipe positDivAsserts chk (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .inReady (inReady),
    .outValid(outValid),
    .outReady(outReady),
    .outData (outData)
  );

  ////////////////////
  // reference words
  ////////////////////

  // 2^scale as a posit with regime run, two exponent bits and a zero fraction
  function automatic posWord_t pow2Word(input int scale);
    int       k;
    int       e;
    int       pos;
    posWord_t w;
    k   = scale >>> 2;                      // floor of scale / 4
    e   = scale & 3;
    w   = '0;
    pos = posN - 2;                         // first bit under the sign
    if (k >= 0)
    begin
      for (int i = 0; i <= k; i++)
      begin
        w[pos] = 1'b1;                      // k+1 ones
        pos--;
      end
      pos--;                                // zero terminator
    end
    else
    begin
      pos    = pos + k;                     // skip -k zeros
      w[pos] = 1'b1;
      pos--;
    end
    if (pos >= 0)
      w[pos] = e[1];
    if (pos >= 1)
      w[pos-1] = e[0];
    return w;
  endfunction

  function automatic posWord_t randWord();
    posWord_t w;
    w = posWord_t'($urandom());
    while (w == posZero || w == posNar)     // ordinary nonzero reals only
      w = posWord_t'($urandom());
    return w;
  endfunction

  ////////////////////
  // stimulus
  ////////////////////

  // holds the pair until accepted and then queues the expected word
  task automatic sendOp(input posWord_t a, input posWord_t b, input posWord_t want);
    bit taken;
    inValid  = 1'b1;
    inData.a = a;
    inData.b = b;
    taken    = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = inReady;                      // transfer on the coming edge
      @(posedge clk);
      #1;
    end
    expQ.push_back(want);
  endtask

  task automatic idleCycles(input int n);
    inValid = 1'b0;
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic specialOp(input int kind);
    posWord_t x;
    x = randWord();
    case (kind)
      0:       sendOp(posZero, x, posZero);
      1:       sendOp(x, posZero, posNar);  // divide by zero
      2:       sendOp(posNar, x, posNar);
      default: sendOp(x, posNar, posNar);
    endcase
  endtask

  task automatic identityOp(input int kind);
    posWord_t x;
    x = randWord();
    case (kind)
      0:       sendOp(x, x, posOne);
      1:       sendOp(x, posOne, x);
      default: sendOp(x, -x, posNegOne);    // opposite signs
    endcase
  endtask

  // 2^m / 2^j with optional negation of either side
  task automatic powerRatioOp(input bit withSigns);
    int       m;
    int       j;
    bit       negA;
    bit       negB;
    posWord_t a;
    posWord_t b;
    posWord_t q;
    m    = int'($urandom_range(47)) - 24;
    j    = int'($urandom_range(48)) - 24;   // m-j stays in [-48,47] where powers are exact
    negA = withSigns && ($urandom_range(1) == 1);
    negB = withSigns && ($urandom_range(1) == 1);
    a    = pow2Word(m);
    b    = pow2Word(j);
    q    = pow2Word(m - j);
    if (negA)
      a = -a;
    if (negB)
      b = -b;
    if (negA != negB)
      q = -q;
    sendOp(a, b, q);
  endtask

  ////////////////////
  // clock, ready, monitor
  ////////////////////

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  always @(posedge clk)
  begin
    #1;
    if (randomReady)
      outReady = ($urandom_range(2) == 0);  // mostly low to fill the pipe
    else
      outReady = 1'b1;
  end

  // sampled at the falling edge ahead of the transfer edge
  always @(negedge clk)
  begin
    if (arstN && outValid && outReady)
    begin
      if (expQ.size() == 0)
      begin
        $display("unexpected output %h at %0t with no input pending", outData, $time);
        orderErrors++;
      end
      else
      begin
        expWord = expQ.pop_front();
        if (outData !== expWord)
        begin
          $display("FAILED at %0t: outData expected %h, got %h", $time, expWord, outData);
          dataErrors++;
        end
      end
    end
  end

  ////////////////////
  // end of run
  ////////////////////

  task automatic finishRun(input bit timedOut);
    int assertFails;
    assertFails = u_dut.chk.failCount;
    $display("errors: %0d mismatches, %0d unexpected outputs, %0d assertion failures",
             dataErrors, orderErrors, assertFails);
    if (timedOut || (dataErrors + orderErrors + assertFails) != 0)
      $display("=== FAIL ===");
    else
      $display("=== PASS ===");
    $finish;
  endtask

  initial
  begin
    wait (cycleCount >= cycleLimit);
    $display("timeout after %0d cycles, %0d results still pending", cycleCount, expQ.size());
    finishRun(1'b1);
  end

  initial
  begin
    void'($urandom(32'h61a9));
    arstN    = 1'b0;
    inValid  = 1'b0;
    inData   = '0;
    outReady = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;

    // directed groups with outReady held high
    for (int i = 0; i < 8; i++)
    begin
      for (int kind = 0; kind < 4; kind++)
        specialOp(kind);
      idleCycles(3);                        // lone last pair pins the latency
    end
    sendOp(posZero, posZero, posNar);       // NaR beats zero
    sendOp(posNar, posNar, posNar);
    sendOp(posNar, posZero, posNar);
    sendOp(posZero, posNar, posNar);
    for (int i = 0; i < 40; i++)
    begin
      identityOp(0);
      identityOp(1);
    end
    for (int i = 0; i < 20; i++)
    begin
      powerRatioOp(1'b1);
      identityOp(2);
    end
    for (int i = 0; i < nPow; i++)
      powerRatioOp(1'b0);

    // random mix under back-pressure with input gaps
    randomReady = 1'b1;
    for (int i = 0; i < nFlow; i++)
    begin
      case ($urandom_range(3))
        0:       specialOp(int'($urandom_range(3)));
        1:       identityOp(int'($urandom_range(2)));
        2:       powerRatioOp(1'b1);
        default: powerRatioOp(1'b0);
      endcase
      if ($urandom_range(7) == 0)
        idleCycles(1 + int'($urandom_range(2)));
    end

    // drain and then a quiet stretch to catch repeats
    inValid     = 1'b0;
    randomReady = 1'b0;
    while (expQ.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);
    finishRun(1'b0);
  end

endmodule : positDivTb

`default_nettype wire

// File: vlog.f
verilog/positPkg.sv
verilog/positDecode.sv
verilog/positDivArith.sv
verilog/positEncode.sv
verilog/positDivPipe.sv
dv/positDiv_asserts.sv
dv/positDivTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the posit divider testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module positDivTb -o positDivSim

# the log decides, a nonzero exit also counts as failure
status=0
./obj_dir/positDivSim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
